//--- src.f
hdl/lcd_pkg.sv
hdl/axil_pkg.sv
hdl/lcd_cmd_if.sv
hdl/lcd_ctrl.sv
hdl/lcd_arbiter.sv
hdl/axil_lcd_regs.sv
hdl/lcd_text_refresh.sv
hdl/lcd_subsys_top.sv
verification/lcd_subsys_assertions.sv
verification/tb_lcd_subsys.sv

//--- Makefile
TOP       ?= tb_lcd_subsys
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
BIN        = $(BUILD_DIR)/V$(TOP)
SOURCES    = $(wildcard hdl/*.sv verification/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# the fail message in the log decides, a run without the pass message also fails
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "simulation ended early, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/lcd_input.txt
# op a b c, all hex. T test id | W addr wdata bresp | R addr rdata rresp | P addr mask
# L lcd word {rs,rw,data} | B buffer index, LFSR char | F refresh | I refresh with raw cmd a
T 1 0 0
L 038 0 0
L 00c 0 0
L 001 0 0
L 006 0 0
P 8 00000001 0
R 8 00000001 0
T 2 0 0
W 4 00000241 0
L 241 0 0
W 4 000000c5 0
L 0c5 0 0
T 3 0 0
B 3 0 0
B 7 0 0
B 8 0 0
B f 0 0
F 0 0 0
R 8 00000001 0
T 4 0 0
B 5 0 0
I 00e 0 0
R 8 00000001 0
T 5 0 0
W 4 00000022 0
L 022 0 0
W 4 00000033 0
W 4 00000044 2
L 033 0 0
W 2 00000011 2
R 2 00000000 2
W 0 0000005a 0
R 0 0000005a 0

//--- verification/tb_lcd_subsys.sv
`timescale 1ns/1ps

module tb_lcd_subsys;
	import lcd_pkg::*;
	import axil_pkg::*;

	localparam int CLK_HALF = 4;
	localparam int AXI_WAIT = 50;
	localparam int WAIT_CYC = 4000;  // covers power-up before the first write
	localparam int POLL_MAX = 500;

	logic                 clk;
	logic                 arst_n;
	logic [AXIL_AW-1:0]   awaddr;
	logic                 awvalid;
	logic                 awready;
	logic [AXIL_DW-1:0]   wdata;
	logic [AXIL_DW/8-1:0] wstrb;
	logic                 wvalid;
	logic                 wready;
	logic [1:0]           bresp;
	logic                 bvalid;
	logic                 bready;
	logic [AXIL_AW-1:0]   araddr;
	logic                 arvalid;
	logic                 arready;
	logic [AXIL_DW-1:0]   rdata;
	logic [1:0]           rresp;
	logic                 rvalid;
	logic                 rready;
	logic                 e;
	logic                 rs;
	logic                 rw;
	logic [7:0]           data;

	logic [7:0]  op_q [$];
	logic [31:0] a_q [$];
	logic [31:0] b_q [$];
	logic [31:0] c_q [$];
	lcd_cmd_t    lcd_q [$];  // writes seen on the lcd bus
	logic [7:0]  model [LINE_CHARS];  // expected line buffer
	logic [31:0] lfsr = 32'h1dbe;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          cur_test = 0;
	int          err_mark = 0;
	int          limit_cyc = 0;

	lcd_subsys_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	initial begin
		forever begin
			@(posedge e);
			@(negedge clk);  // bus is held for the whole pulse
			lcd_q.push_back(lcd_cmd_t'({rs, rw, data}));
		end
	end

	initial begin
		wait (limit_cyc > 0);
		repeat (limit_cyc) @(posedge clk);
		$display("watchdog expired after %0d cycles", limit_cyc);
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_char(output logic [7:0] c);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			c    = {c[6:0], lfsr[0]};
		end
	endtask

	task automatic check_cmd(input string name, input lcd_cmd_t got, input lcd_cmd_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s expected 0x%03h got 0x%03h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s expected 0x%h got 0x%h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_rdata(input string name, input logic [AXIL_DW-1:0] got,
			input logic [AXIL_DW-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s expected 0x%08h got 0x%08h", name, exp, got);
			errors++;
		end
	endtask

	task automatic load_ops();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("verification/lcd_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/lcd_input.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				if ($sscanf(line, "%c %h %h %h", op, a, b, c) == 4) begin
					op_q.push_back(op);
					a_q.push_back(a);
					b_q.push_back(b);
					c_q.push_back(c);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic axi_write(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] wd,
			output logic [1:0] resp);
		int n;
		@(negedge clk);
		awaddr  = addr;
		wdata   = wd;
		wstrb   = '1;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		@(negedge clk);
		while (!awready && n < AXI_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (!awready) begin
			$display("write to 0x%h not accepted within %0d cycles", addr, AXI_WAIT);
			errors++;
		end else if (!wready) begin
			$display("wready did not rise together with awready on the write to 0x%h", addr);
			errors++;
		end
		@(negedge clk);  // handshake edge has passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid && n < AXI_WAIT) begin
			@(negedge clk);
			n++;
		end
		resp   = bvalid ? bresp : 2'b11;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [AXIL_AW-1:0] addr, output logic [AXIL_DW-1:0] rd,
			output logic [1:0] resp);
		int n;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		@(negedge clk);
		while (!arready && n < AXI_WAIT) begin
			@(negedge clk);
			n++;
		end
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid && n < AXI_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (!rvalid) begin
			$display("no read response from 0x%h within %0d cycles", addr, AXI_WAIT);
			errors++;
		end
		rd     = rdata;
		resp   = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic poll_status(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] mask);
		logic [AXIL_DW-1:0] rd;
		logic [1:0]         resp;
		int                 tries;
		tries = 0;
		do begin
			axi_read(addr, rd, resp);
			tries++;
		end while ((rd & mask) == '0 && tries < POLL_MAX);
		if ((rd & mask) == '0) begin
			$display("status bits 0x%h never set after %0d reads", mask, tries);
			errors++;
		end
	endtask

	task automatic next_lcd(output lcd_cmd_t c, output bit ok);
		int n;
		n = 0;
		while (lcd_q.size() == 0 && n < WAIT_CYC) begin
			@(posedge clk);  // monitor pushes on the falling edge
			n++;
		end
		ok = (lcd_q.size() != 0);
		if (ok) begin
			c = lcd_q.pop_front();
		end else begin
			$display("no LCD write within %0d cycles", WAIT_CYC);
			errors++;
		end
	endtask

	task automatic buf_write(input logic [3:0] idx);
		logic [7:0] ch;
		logic [1:0] resp;
		rand_char(ch);
		model[idx] = ch;
		axi_write(REG_BUF, {20'd0, idx, ch}, resp);
		check_resp("bresp", resp, RESP_OKAY);
	endtask

	task automatic run_refresh(input bit with_raw, input lcd_cmd_t raw);
		lcd_cmd_t   exp_seq [LINE_CHARS+1];
		lcd_cmd_t   got;
		logic [1:0] resp;
		bit         ok;
		int         pos;
		int         raw_seen;
		exp_seq[0] = lcd_cmd_t'({1'b0, 1'b0, LCD_CMD_SET_DDRAM});
		for (int i = 0; i < LINE_CHARS; i++)
			exp_seq[i+1] = lcd_cmd_t'({1'b1, 1'b0, model[i]});  // chars go out with rs=1
		axi_write(REG_BUF, {1'b1, 19'd0, 4'd0, model[0]}, resp);  // index 0 keeps its char
		check_resp("bresp", resp, RESP_OKAY);
		if (with_raw) begin
			axi_write(REG_CMD, AXIL_DW'(raw), resp);
			check_resp("bresp", resp, RESP_OKAY);
		end
		pos      = 0;
		raw_seen = 0;
		for (int n = 0; n < LINE_CHARS + 1 + int'(with_raw); n++) begin
			next_lcd(got, ok);
			if (!ok)
				break;
			if (with_raw && raw_seen == 0 && got == raw) begin
				raw_seen++;
				if (n > 1) begin  // round robin lets it in after one refresh command
					$display("raw command came as LCD write %0d, not within the first two", n);
					errors++;
				end
			end else if (pos < LINE_CHARS + 1) begin
				check_cmd("lcd_bus", got, exp_seq[pos]);
				pos++;
			end
		end
		if (with_raw && raw_seen != 1) begin
			$display("raw command did not appear on the LCD bus during the refresh");
			errors++;
		end
	endtask

	task automatic finish_test();
		if (cur_test != 0) begin
			tests_run++;
			$display("test %0d %s, %0d errors", cur_test,
				(errors == err_mark) ? "passed" : "failed", errors - err_mark);
		end
	endtask

	initial begin
		logic [1:0]         resp;
		logic [AXIL_DW-1:0] rd;
		lcd_cmd_t           got;
		bit                 ok;
		int                 n_lcd;
		arst_n  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		for (int i = 0; i < LINE_CHARS; i++)
			model[i] = CHAR_SPACE;
		load_ops();
		n_lcd = 0;
		foreach (op_q[i])
			if (op_q[i] == "F" || op_q[i] == "I")
				n_lcd += LINE_CHARS + 1;
		limit_cyc = 2 * (T_POWERUP * CLK_PER_US + (op_q.size() + n_lcd) * T_CMD * CLK_PER_US);
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		foreach (op_q[i]) begin
			case (op_q[i])
				"T": begin
					finish_test();
					cur_test = int'(a_q[i]);
					err_mark = errors;
				end
				"W": begin
					axi_write(a_q[i][AXIL_AW-1:0], b_q[i], resp);
					check_resp("bresp", resp, c_q[i][1:0]);
				end
				"R": begin
					axi_read(a_q[i][AXIL_AW-1:0], rd, resp);
					check_rdata("rdata", rd, b_q[i]);
					check_resp("rresp", resp, c_q[i][1:0]);
				end
				"P": poll_status(a_q[i][AXIL_AW-1:0], b_q[i]);
				"L": begin
					next_lcd(got, ok);
					if (ok)
						check_cmd("lcd_bus", got, lcd_cmd_t'(a_q[i][9:0]));
				end
				"B": buf_write(a_q[i][3:0]);
				"F": run_refresh(1'b0, '0);
				"I": run_refresh(1'b1, lcd_cmd_t'(a_q[i][9:0]));
				default: begin
					$display("unknown operation %c in the input file", op_q[i]);
					errors++;
				end
			endcase
		end
		finish_test();
		repeat (2 * T_CMD * CLK_PER_US) @(posedge clk);
		if (lcd_q.size() != 0) begin
			$display("%0d unexpected LCD writes after the last test", lcd_q.size());
			errors++;
		end
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- verification/lcd_subsys_assertions.sv
`timescale 1ns/1ps

module lcd_subsys_assertions (
	input logic              clk,
	input logic              arst_n,
	input logic              init_done,
	input logic              e,
	input logic [7:0]        data,
	input logic              valid,
	input logic              ready,
	input lcd_pkg::lcd_cmd_t cmd
);
	logic       e_q;
	logic [2:0] init_rises;  // e pulses seen before init_done

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			e_q        <= 1'b0;
			init_rises <= '0;
		end else begin
			e_q <= e;
			if (e && !e_q && !init_done && init_rises != 3'd7)
				init_rises <= init_rises + 1'b1;
		end
	end

	data_stable_in_e: assert property (@(posedge clk) disable iff (!arst_n)
		e && $past(e) |-> data == $past(data))
		else $error("lcd data changed while e was high");

	four_init_pulses: assert property (@(posedge clk) disable iff (!arst_n)
		e && !e_q && !init_done |-> init_rises < 3'd4)
		else $error("e pulse before init_done beyond the four init commands");

	valid_held: assert property (@(posedge clk) disable iff (!arst_n)
		valid && !ready |=> valid && $stable(cmd))
		else $error("cmd_in valid dropped or cmd changed before ready");

endmodule

bind lcd_ctrl lcd_subsys_assertions u_assertions (
	.clk       (clk),
	.arst_n    (arst_n),
	.init_done (init_done),
	.e         (e),
	.data      (data),
	.valid     (cmd_in.valid),
	.ready     (cmd_in.ready),
	.cmd       (cmd_in.cmd)
);

//--- hdl/lcd_subsys_top.sv
`timescale 1ns/1ps

module lcd_subsys_top (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic [axil_pkg::AXIL_AW-1:0]   awaddr,
	input  logic                           awvalid,
	output logic                           awready,
	input  logic [axil_pkg::AXIL_DW-1:0]   wdata,
	input  logic [axil_pkg::AXIL_DW/8-1:0] wstrb,
	input  logic                           wvalid,
	output logic                           wready,
	output logic [1:0]                     bresp,
	output logic                           bvalid,
	input  logic                           bready,
	input  logic [axil_pkg::AXIL_AW-1:0]   araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output logic [axil_pkg::AXIL_DW-1:0]   rdata,
	output logic [1:0]                     rresp,
	output logic                           rvalid,
	input  logic                           rready,
	output logic                           e,
	output logic                           rs,
	output logic                           rw,
	output logic [7:0]                     data
);
	import lcd_pkg::*;

	lcd_cfg_t   cfg;
	logic       init_done;
	logic       buf_we;
	logic [3:0] buf_idx;
	logic [7:0] buf_char;
	logic       refresh_start;
	logic       refresh_busy;

	lcd_cmd_if req_if [2] ();  // 0 raw register commands, 1 text refresh
	lcd_cmd_if ctrl_if ();

	axil_lcd_regs u_regs (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.cfg, .init_done,
		.cmd_out       (req_if[0]),
		.buf_we, .buf_idx, .buf_char, .refresh_start, .refresh_busy
	);

	lcd_text_refresh u_refresh (
		.clk, .arst_n,
		.buf_we, .buf_idx, .buf_char, .refresh_start, .refresh_busy,
		.cmd_out       (req_if[1])
	);

	lcd_arbiter #(.NUM_REQ(2)) u_arbiter (
		.clk, .arst_n,
		.req           (req_if),
		.grant_out     (ctrl_if)
	);

	lcd_ctrl u_ctrl (
		.clk, .arst_n,
		.cfg,
		.cmd_in        (ctrl_if),
		.init_done,
		.e, .rs, .rw, .data
	);

endmodule

//--- hdl/lcd_text_refresh.sv
`timescale 1ns/1ps

module lcd_text_refresh (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         buf_we,
	input  logic [3:0]   buf_idx,
	input  logic [7:0]   buf_char,
	input  logic         refresh_start,
	output logic         refresh_busy,
	lcd_cmd_if.requester cmd_out
);
	import lcd_pkg::*;

	logic [7:0] line_buf [LINE_CHARS];
	logic [4:0] seq;  // 0 is the address command, then one step per char
	logic [3:0] char_idx;

	assign char_idx      = 4'(seq - 5'd1);
	assign cmd_out.valid = refresh_busy;
	assign cmd_out.cmd   = (seq == 5'd0) ? {1'b0, 1'b0, LCD_CMD_SET_DDRAM}
	                                     : {1'b1, 1'b0, line_buf[char_idx]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < LINE_CHARS; i++)
				line_buf[i] <= CHAR_SPACE;
		end else if (buf_we) begin
			line_buf[buf_idx] <= buf_char;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			refresh_busy <= 1'b0;
			seq          <= '0;
		end else if (!refresh_busy) begin
			if (refresh_start) begin
				refresh_busy <= 1'b1;
				seq          <= '0;
			end
		end else if (cmd_out.valid && cmd_out.ready) begin
			if (seq == 5'(LINE_CHARS))  // last char sent
				refresh_busy <= 1'b0;
			else
				seq <= seq + 1'b1;
		end
	end

endmodule

//--- hdl/axil_lcd_regs.sv
`timescale 1ns/1ps

module axil_lcd_regs (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [axil_pkg::AXIL_AW-1:0]    awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [axil_pkg::AXIL_DW-1:0]    wdata,
	input  logic [axil_pkg::AXIL_DW/8-1:0]  wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic [axil_pkg::AXIL_AW-1:0]    araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [axil_pkg::AXIL_DW-1:0]    rdata,
	output logic [1:0]                      rresp,
	output logic                            rvalid,
	input  logic                            rready,
	output lcd_pkg::lcd_cfg_t               cfg,
	input  logic                            init_done,
	lcd_cmd_if.requester                    cmd_out,
	output logic                            buf_we,
	output logic [3:0]                      buf_idx,
	output logic [7:0]                      buf_char,
	output logic                            refresh_start,
	input  logic                            refresh_busy
);
	import axil_pkg::*;
	import lcd_pkg::*;

	logic     cmd_pending;
	lcd_cmd_t cmd_q;
	logic     wr_hs;
	logic     rd_hs;

	assign wr_hs         = awready && awvalid && wvalid;
	assign rd_hs         = arready && arvalid;
	assign cmd_out.valid = cmd_pending;
	assign cmd_out.cmd   = cmd_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awready       <= 1'b0;
			wready        <= 1'b0;
			bvalid        <= 1'b0;
			cfg           <= CFG_RESET;
			cmd_pending   <= 1'b0;
			buf_we        <= 1'b0;
			refresh_start <= 1'b0;
		end else begin
			buf_we        <= 1'b0;
			refresh_start <= 1'b0;
			if (cmd_out.valid && cmd_out.ready)
				cmd_pending <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			awready <= awvalid && wvalid && !awready && !bvalid;  // one-cycle pulse
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (wr_hs) begin
				bvalid <= 1'b1;
				bresp  <= RESP_OKAY;
				case (awaddr)
					REG_CFG: begin
						if (wstrb[0])
							cfg <= lcd_cfg_t'(wdata[6:0]);
					end
					REG_CMD: begin
						if (cmd_pending) begin
							bresp <= RESP_SLVERR;  // previous command not yet sent
						end else begin
							cmd_q       <= lcd_cmd_t'(wdata[9:0]);
							cmd_pending <= 1'b1;
						end
					end
					REG_BUF: begin
						if (refresh_busy) begin
							bresp <= RESP_SLVERR;
						end else begin
							buf_we        <= 1'b1;
							buf_idx       <= wdata[11:8];
							buf_char      <= wdata[7:0];
							refresh_start <= wdata[BUF_START_BIT];
						end
					end
					default: bresp <= RESP_SLVERR;  // status is read only
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_hs) begin
				rvalid <= 1'b1;
				rresp  <= RESP_OKAY;
				case (araddr)
					REG_CFG:    rdata <= AXIL_DW'(cfg);
					REG_STATUS: rdata <= AXIL_DW'({refresh_busy, cmd_pending, init_done});
					default: begin  // write-only or unmapped
						rdata <= '0;
						rresp <= RESP_SLVERR;
					end
				endcase
			end
		end
	end

endmodule

//--- hdl/lcd_arbiter.sv
`timescale 1ns/1ps

module lcd_arbiter #(
	parameter int NUM_REQ = 2
) (
	input  logic         clk,
	input  logic         arst_n,
	lcd_cmd_if.responder req [NUM_REQ],
	lcd_cmd_if.requester grant_out
);
	import lcd_pkg::*;

	localparam int IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

	logic [NUM_REQ-1:0] valid_v;
	lcd_cmd_t           cmd_v [NUM_REQ];
	logic [IDX_W-1:0]   ptr;  // first requester to look at
	logic [IDX_W-1:0]   sel_rr;
	logic [IDX_W-1:0]   sel_q;
	logic [IDX_W-1:0]   sel;
	logic               locked;  // grant frozen until the transfer

	for (genvar i = 0; i < NUM_REQ; i++) begin : g_req
		assign valid_v[i]   = req[i].valid;
		assign cmd_v[i]     = req[i].cmd;
		assign req[i].ready = grant_out.ready && (sel == IDX_W'(i));
	end

	always_comb begin
		int cand;
		sel_rr = ptr;
		for (int k = NUM_REQ - 1; k >= 0; k--) begin  // lowest offset from ptr wins
			cand = (int'(ptr) + k) % NUM_REQ;
			if (valid_v[cand])
				sel_rr = IDX_W'(cand);
		end
	end

	assign sel             = locked ? sel_q : sel_rr;
	assign grant_out.valid = valid_v[sel];
	assign grant_out.cmd   = cmd_v[sel];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr    <= '0;
			sel_q  <= '0;
			locked <= 1'b0;
		end else if (grant_out.valid && grant_out.ready) begin
			locked <= 1'b0;
			ptr    <= (int'(sel) == NUM_REQ - 1) ? '0 : sel + 1'b1;
		end else if (grant_out.valid) begin
			locked <= 1'b1;
			sel_q  <= sel;
		end
	end

endmodule

//--- hdl/lcd_ctrl.sv
`timescale 1ns/1ps

module lcd_ctrl (
	input  logic              clk,
	input  logic              arst_n,
	input  lcd_pkg::lcd_cfg_t cfg,
	lcd_cmd_if.responder      cmd_in,
	output logic              init_done,
	output logic              e,
	output logic              rs,
	output logic              rw,
	output logic [7:0]        data
);
	import lcd_pkg::*;

	localparam int PWR_CYC  = T_POWERUP * CLK_PER_US;
	localparam int PULSE    = T_INIT_PULSE * CLK_PER_US;
	localparam int DC_BEG   = PULSE + T_WAIT_SHORT * CLK_PER_US;
	localparam int CL_BEG   = DC_BEG + PULSE + T_WAIT_SHORT * CLK_PER_US;
	localparam int EM_BEG   = CL_BEG + PULSE + T_WAIT_CLEAR * CLK_PER_US;
	localparam int INIT_CYC = EM_BEG + PULSE + T_WAIT_ENTRY * CLK_PER_US;
	localparam int E_RISE   = T_E_SETUP * CLK_PER_US;
	localparam int E_FALL   = E_RISE + T_E_HIGH * CLK_PER_US;
	localparam int E_DONE   = E_FALL + T_E_LOW * CLK_PER_US;
	// the E low half cycle always completes, even with a short T_CMD
	localparam int XFER_CYC = (T_CMD * CLK_PER_US > E_DONE) ? T_CMD * CLK_PER_US : E_DONE;
	localparam int CNT_MAX  = (PWR_CYC > INIT_CYC) ? PWR_CYC : INIT_CYC;
	localparam int CNT_W    = $clog2(((CNT_MAX > XFER_CYC) ? CNT_MAX : XFER_CYC) + 1);

	typedef enum logic [1:0] {ST_POWERUP, ST_INIT, ST_IDLE, ST_XFER} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;  // cycle count within the current phase
	int               cnt_i;
	lcd_cfg_t         cfg_q;
	logic             init_e;
	logic [7:0]       init_byte;

	assign cnt_i        = int'(cnt);
	assign cmd_in.ready = (state == ST_IDLE);

	always_comb begin
		init_e    = 1'b0;
		init_byte = 8'h00;  // bus reads 0 between init pulses
		if (cnt_i < PULSE) begin  // function set, 8-bit bus
			init_e    = 1'b1;
			init_byte = {4'b0011, cfg_q.display_lines, cfg_q.font, 2'b00};
		end else if (cnt_i >= DC_BEG && cnt_i < DC_BEG + PULSE) begin  // display on/off
			init_e    = 1'b1;
			init_byte = {5'b00001, cfg_q.display_on, cfg_q.cursor, cfg_q.blink};
		end else if (cnt_i >= CL_BEG && cnt_i < CL_BEG + PULSE) begin  // clear
			init_e    = 1'b1;
			init_byte = 8'h01;
		end else if (cnt_i >= EM_BEG && cnt_i < EM_BEG + PULSE) begin  // entry mode
			init_e    = 1'b1;
			init_byte = {6'b000001, cfg_q.inc_dec, cfg_q.shift};
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_POWERUP && cnt_i == PWR_CYC - 1)
			cfg_q <= cfg;  // config is frozen for the whole init
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_POWERUP;
			cnt       <= '0;
			init_done <= 1'b0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			data      <= 8'h00;
		end else begin
			case (state)
				ST_POWERUP: begin
					if (cnt_i == PWR_CYC - 1) begin
						cnt   <= '0;
						state <= ST_INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_INIT: begin
					e    <= init_e;
					data <= init_byte;
					if (cnt_i == INIT_CYC - 1) begin  // ends inside the entry mode wait
						cnt       <= '0;
						init_done <= 1'b1;
						state     <= ST_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_IDLE: begin
					if (cmd_in.valid) begin
						rs    <= cmd_in.cmd.rs;
						rw    <= cmd_in.cmd.rw;
						data  <= cmd_in.cmd.data;
						cnt   <= '0;
						state <= ST_XFER;
					end
				end
				ST_XFER: begin
					e <= (cnt_i + 1 >= E_RISE) && (cnt_i + 1 < E_FALL);
					if (cnt_i == XFER_CYC - 1) begin
						rs    <= 1'b0;
						rw    <= 1'b0;
						data  <= 8'h00;
						cnt   <= '0;
						state <= ST_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

//--- hdl/lcd_cmd_if.sv
`timescale 1ns/1ps

interface lcd_cmd_if;
	import lcd_pkg::*;

	logic     valid;
	logic     ready;
	lcd_cmd_t cmd;  // stable while valid is high

	modport requester (
		output valid,
		output cmd,
		input  ready
	);

	modport responder (
		input  valid,
		input  cmd,
		output ready
	);

endinterface

//--- hdl/axil_pkg.sv
package axil_pkg;

	localparam int AXIL_AW = 4;
	localparam int AXIL_DW = 32;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// register map, byte offsets
	localparam logic [AXIL_AW-1:0] REG_CFG    = 4'h0;
	localparam logic [AXIL_AW-1:0] REG_CMD    = 4'h4;
	localparam logic [AXIL_AW-1:0] REG_STATUS = 4'h8;
	localparam logic [AXIL_AW-1:0] REG_BUF    = 4'hC;

	// fields of REG_BUF
	localparam int BUF_START_BIT = 31;

endpackage

//--- hdl/lcd_pkg.sv
package lcd_pkg;

	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_cmd_t;  // same bit order as the 10-bit lcd bus word

	typedef struct packed {
		logic display_lines;
		logic font;
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;
		logic shift;
	} lcd_cfg_t;

	localparam int CLK_PER_US = 2;

	// init delays in us
	localparam int T_POWERUP    = 500;
	localparam int T_INIT_PULSE = 10;
	localparam int T_WAIT_SHORT = 50;
	localparam int T_WAIT_CLEAR = 200;
	localparam int T_WAIT_ENTRY = 100;

	// per-command transfer timing in us
	localparam int T_E_SETUP = 1;
	localparam int T_E_HIGH  = 13;
	localparam int T_E_LOW   = 13;
	localparam int T_CMD     = 50;

	localparam logic [7:0] LCD_CMD_SET_DDRAM = 8'h80;
	localparam logic [7:0] CHAR_SPACE        = 8'h20;
	localparam int         LINE_CHARS        = 16;

	localparam lcd_cfg_t CFG_RESET = 7'b1010010;  // 2 lines, 5x8, display on, increment

endpackage
